//--- rtl/cl_irq_pkg.sv
`default_nettype none

/*
 Shared constants of the interrupt test design
 Data widths, host address map, configuration offsets and response codes
*/
package cl_irq_pkg;

   // Bus widths
   localparam DATA_W     = 32;
   localparam ADDR_W     = 32;
   localparam CFG_ADDR_W = 8;
   localparam NUM_IRQ    = 16;

   // Value returned by the identification register
   localparam [DATA_W-1:0] CL_ID_VALUE = 32'hF000_1D0F;

   // ------------------------------
   // Host address map
   // ------------------------------
   localparam [ADDR_W-1:0] ADDR_ID      = 32'h0000_0000;
   localparam [ADDR_W-1:0] ADDR_SCRATCH = 32'h0000_0008;
   // Address bit that steers an access onto the configuration bus
   localparam CFG_WINDOW_BIT = 12;

   // Interrupt block offsets on the configuration bus
   localparam [CFG_ADDR_W-1:0] CFG_TRIGGER   = 8'h00;
   localparam [CFG_ADDR_W-1:0] CFG_PENDING   = 8'h04;
   localparam [CFG_ADDR_W-1:0] CFG_ACK_COUNT = 8'h08;

   // Read data for holes in the map
   localparam [DATA_W-1:0] UNMAPPED_RDATA = 32'hDEAD_DEAD;

   // Host response codes
   localparam [1:0] RESP_OKAY   = 2'b00;
   localparam [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- rtl/rst_slc_pipe.sv
`default_nettype none

/*
 Reset slice pipe
 One common synchronised reset, then a delayed copy per block
*/
module rst_slc_pipe #(
   parameter RST_STAGES = 4
)
(
   input  wire  clk,
   input  wire  pipe_rst_n,
   output logic ocl_rst_n,
   output logic int_rst_n
);

   logic                  sync_rst_n;
   logic [RST_STAGES-1:0] ocl_slc;
   logic [RST_STAGES-1:0] int_slc;

   // Assertion clears every flop on the next edge
   // Release ripples through the slices one stage per cycle
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         sync_rst_n <= 1'b0;
         ocl_slc    <= '0;
         int_slc    <= '0;
      end
      else
      begin
         sync_rst_n <= 1'b1;
         ocl_slc[0] <= sync_rst_n;
         int_slc[0] <= sync_rst_n;
         for (int i = 1; i < RST_STAGES; i++)
         begin
            ocl_slc[i] <= ocl_slc[i-1];
            int_slc[i] <= int_slc[i-1];
         end
      end
   end

   assign ocl_rst_n = ocl_slc[RST_STAGES-1];
   assign int_rst_n = int_slc[RST_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/cfg_stage_pipe.sv
`default_nettype none

/*
 Configuration bus stage pipe
 Fixed latency register chain with no back-pressure
*/
module cfg_stage_pipe #(
   parameter WIDTH      = 1,
   parameter CFG_STAGES = 4
)
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire  [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   logic [WIDTH-1:0] stage [0:CFG_STAGES-1];

   // Every stage is cleared so no stray request or ack leaves reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < CFG_STAGES; i++)
            stage[i] <= '0;
      end
      else
      begin
         stage[0] <= in_bus;
         // One item may enter per cycle
         for (int i = 1; i < CFG_STAGES; i++)
            stage[i] <= stage[i-1];
      end
   end

   assign out_bus = stage[CFG_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/ocl_slv.sv
`default_nettype none

/*
 OCL register slave
 Serves one host access at a time from local registers or forwards it
 onto the configuration bus, and answers the function-level reset
*/
module ocl_slv
   import cl_irq_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire                   flr_assert,
   output logic                  flr_done,
   // Host port
   input  wire                   aw_valid,
   input  wire  [ADDR_W-1:0]     aw_addr,
   output logic                  aw_ready,
   input  wire                   w_valid,
   input  wire  [DATA_W-1:0]     w_data,
   input  wire  [DATA_W/8-1:0]   w_strb,
   output logic                  w_ready,
   output logic                  b_valid,
   output logic [1:0]            b_resp,
   input  wire                   b_ready,
   input  wire                   ar_valid,
   input  wire  [ADDR_W-1:0]     ar_addr,
   output logic                  ar_ready,
   output logic                  r_valid,
   output logic [DATA_W-1:0]     r_data,
   output logic [1:0]            r_resp,
   input  wire                   r_ready,
   // Configuration bus master
   output logic                  cfg_wr,
   output logic                  cfg_rd,
   output logic [CFG_ADDR_W-1:0] cfg_addr,
   output logic [DATA_W-1:0]     cfg_wdata,
   input  wire                   cfg_ack,
   input  wire  [DATA_W-1:0]     cfg_rdata
);

   localparam [2:0] ST_IDLE   = 3'd0;
   localparam [2:0] ST_ADDR   = 3'd1;
   localparam [2:0] ST_DECODE = 3'd2;
   localparam [2:0] ST_LOCAL  = 3'd3;
   localparam [2:0] ST_CFG    = 3'd4;
   localparam [2:0] ST_RESP   = 3'd5;

   logic [2:0]          state;
   logic                is_write;
   logic [ADDR_W-1:0]   addr_q;
   logic [DATA_W-1:0]   wdata_q;
   logic [DATA_W/8-1:0] wstrb_q;
   logic [DATA_W-1:0]   scratch;
   logic                flr_q;
   logic                is_cfg;
   logic                is_id;
   logic                is_scratch;

   // Address decode, window bit first
   assign is_cfg     = addr_q[CFG_WINDOW_BIT];
   assign is_id      = !is_cfg && (addr_q == ADDR_ID);
   assign is_scratch = !is_cfg && (addr_q == ADDR_SCRATCH);

   // ------------------------------
   // Access FSM
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= ST_IDLE;
         is_write <= 1'b0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         ar_ready <= 1'b0;
         b_valid  <= 1'b0;
         r_valid  <= 1'b0;
         cfg_wr   <= 1'b0;
         cfg_rd   <= 1'b0;
      end
      else
      begin
         // Requests are single-cycle pulses
         cfg_wr <= 1'b0;
         cfg_rd <= 1'b0;
         case (state)
            ST_IDLE:
            begin
               // A write needs address and data together and wins over a read
               if (aw_valid && w_valid)
               begin
                  aw_ready <= 1'b1;
                  w_ready  <= 1'b1;
                  is_write <= 1'b1;
                  state    <= ST_ADDR;
               end
               else if (ar_valid)
               begin
                  ar_ready <= 1'b1;
                  is_write <= 1'b0;
                  state    <= ST_ADDR;
               end
            end
            ST_ADDR:
            begin
               // Handshake completes here, valids are held by the host
               aw_ready <= 1'b0;
               w_ready  <= 1'b0;
               ar_ready <= 1'b0;
               state    <= ST_DECODE;
            end
            ST_DECODE:
            begin
               if (is_cfg)
               begin
                  cfg_wr <= is_write;
                  cfg_rd <= !is_write;
                  state  <= ST_CFG;
               end
               else
                  state <= ST_LOCAL;
            end
            ST_LOCAL:
            begin
               b_valid <= is_write;
               r_valid <= !is_write;
               state   <= ST_RESP;
            end
            ST_CFG:
            begin
               // Only one request outstanding, so any ack is ours
               if (cfg_ack)
               begin
                  b_valid <= is_write;
                  r_valid <= !is_write;
                  state   <= ST_RESP;
               end
            end
            ST_RESP:
            begin
               if ((b_valid && b_ready) || (r_valid && r_ready))
               begin
                  b_valid <= 1'b0;
                  r_valid <= 1'b0;
                  state   <= ST_IDLE;
               end
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // Captured access and response payload
   always_ff @(posedge clk)
   begin
      if (state == ST_ADDR)
      begin
         addr_q  <= is_write ? aw_addr : ar_addr;
         wdata_q <= w_data;
         wstrb_q <= w_strb;
      end
      if (state == ST_DECODE)
      begin
         cfg_addr  <= addr_q[CFG_ADDR_W-1:0];
         cfg_wdata <= wdata_q;
         b_resp    <= (is_cfg || is_id || is_scratch) ? RESP_OKAY : RESP_SLVERR;
         r_resp    <= (is_cfg || is_id || is_scratch) ? RESP_OKAY : RESP_SLVERR;
         if (is_id)
            r_data <= CL_ID_VALUE;
         else if (is_scratch)
            r_data <= scratch;
         else
            r_data <= UNMAPPED_RDATA;
      end
      // Window reads take their data from the response path
      if ((state == ST_CFG) && cfg_ack)
         r_data <= cfg_rdata;
   end

   // ------------------------------
   // Scratch register and FLR
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n || flr_q)
         scratch <= '0;
      else if ((state == ST_DECODE) && is_write && is_scratch)
      begin
         for (int i = 0; i < DATA_W/8; i++)
         begin
            if (wstrb_q[i])
               scratch[8*i +: 8] <= wdata_q[8*i +: 8];
         end
      end
   end

   // Done follows the registered FLR, every other cycle if it stays high
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end
   end

endmodule

`default_nettype wire

//--- rtl/int_slv.sv
`default_nettype none

/*
 Interrupt test block
 Raises interrupt requests on command over the configuration bus
 and counts the acknowledges from the host
*/
module int_slv
   import cl_irq_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,
   // Configuration bus slave
   input  wire                   cfg_wr,
   input  wire                   cfg_rd,
   input  wire  [CFG_ADDR_W-1:0] cfg_addr,
   input  wire  [DATA_W-1:0]     cfg_wdata,
   output logic                  cfg_ack,
   output logic [DATA_W-1:0]     cfg_rdata,
   // Interrupt lines
   output logic [NUM_IRQ-1:0]    irq_req,
   input  wire  [NUM_IRQ-1:0]    irq_ack
);

   logic [DATA_W-1:0] ack_count;

   // Number of ack bits set in one cycle
   function automatic logic [DATA_W-1:0] count_acks(input logic [NUM_IRQ-1:0] acks);
      logic [DATA_W-1:0] n;
      n = '0;
      for (int i = 0; i < NUM_IRQ; i++)
         n = n + acks[i];
      return n;
   endfunction

   // ------------------------------
   // Pending vector and counter
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         irq_req   <= '0;
         ack_count <= '0;
      end
      else
      begin
         // Ack drops its bit on the next edge, a trigger sets new ones
         if (cfg_wr && (cfg_addr == CFG_TRIGGER))
            irq_req <= (irq_req & ~irq_ack) | cfg_wdata[NUM_IRQ-1:0];
         else
            irq_req <= irq_req & ~irq_ack;

         // Clearing keeps the acks of the same cycle
         if (cfg_wr && (cfg_addr == CFG_ACK_COUNT))
            ack_count <= count_acks(irq_ack);
         else
            ack_count <= ack_count + count_acks(irq_ack);
      end
   end

   // Every request earns exactly one ack, one cycle later
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         cfg_ack <= 1'b0;
      else
         cfg_ack <= cfg_wr || cfg_rd;
   end

   // Read data, unknown offsets return zero
   always_ff @(posedge clk)
   begin
      if (cfg_rd)
      begin
         case (cfg_addr)
            CFG_PENDING:   cfg_rdata <= {{(DATA_W-NUM_IRQ){1'b0}}, irq_req};
            CFG_ACK_COUNT: cfg_rdata <= ack_count;
            default:       cfg_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/cl_irq_top.sv
`default_nettype none

/*
 Interrupt test top level
 Reset slices, OCL register slave, pipelined configuration bus
 and the interrupt test block
*/
module cl_irq_top
   import cl_irq_pkg::*;
#(
   parameter RST_STAGES = 4,
   parameter CFG_STAGES = 4
)
(
   input  wire                  clk_main_a0,
   input  wire                  pipe_rst_n,
   input  wire                  flr_assert,
   output wire                  flr_done,
   // Host port
   input  wire                  aw_valid,
   input  wire [ADDR_W-1:0]     aw_addr,
   output wire                  aw_ready,
   input  wire                  w_valid,
   input  wire [DATA_W-1:0]     w_data,
   input  wire [DATA_W/8-1:0]   w_strb,
   output wire                  w_ready,
   output wire                  b_valid,
   output wire [1:0]            b_resp,
   input  wire                  b_ready,
   input  wire                  ar_valid,
   input  wire [ADDR_W-1:0]     ar_addr,
   output wire                  ar_ready,
   output wire                  r_valid,
   output wire [DATA_W-1:0]     r_data,
   output wire [1:0]            r_resp,
   input  wire                  r_ready,
   // Interrupt lines
   output wire [NUM_IRQ-1:0]    irq_req,
   input  wire [NUM_IRQ-1:0]    irq_ack
);

   // Pipe widths: wr, rd, addr, wdata / ack, rdata
   localparam REQ_W = 2 + CFG_ADDR_W + DATA_W;
   localparam RSP_W = 1 + DATA_W;

   wire                  ocl_rst_n;
   wire                  int_rst_n;

   // Config bus, slave side
   wire                  ocl_cfg_wr;
   wire                  ocl_cfg_rd;
   wire [CFG_ADDR_W-1:0] ocl_cfg_addr;
   wire [DATA_W-1:0]     ocl_cfg_wdata;
   wire                  ocl_cfg_ack;
   wire [DATA_W-1:0]     ocl_cfg_rdata;
   // Config bus, interrupt block side
   wire                  int_cfg_wr;
   wire                  int_cfg_rd;
   wire [CFG_ADDR_W-1:0] int_cfg_addr;
   wire [DATA_W-1:0]     int_cfg_wdata;
   wire                  int_cfg_ack;
   wire [DATA_W-1:0]     int_cfg_rdata;

   rst_slc_pipe #(.RST_STAGES(RST_STAGES)) rst_slc (
      .clk        (clk_main_a0),
      .pipe_rst_n (pipe_rst_n),
      .ocl_rst_n  (ocl_rst_n),
      .int_rst_n  (int_rst_n)
   );

   ocl_slv ocl (
      .clk        (clk_main_a0),
      .rst_n      (ocl_rst_n),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .aw_valid   (aw_valid),
      .aw_addr    (aw_addr),
      .aw_ready   (aw_ready),
      .w_valid    (w_valid),
      .w_data     (w_data),
      .w_strb     (w_strb),
      .w_ready    (w_ready),
      .b_valid    (b_valid),
      .b_resp     (b_resp),
      .b_ready    (b_ready),
      .ar_valid   (ar_valid),
      .ar_addr    (ar_addr),
      .ar_ready   (ar_ready),
      .r_valid    (r_valid),
      .r_data     (r_data),
      .r_resp     (r_resp),
      .r_ready    (r_ready),
      .cfg_wr     (ocl_cfg_wr),
      .cfg_rd     (ocl_cfg_rd),
      .cfg_addr   (ocl_cfg_addr),
      .cfg_wdata  (ocl_cfg_wdata),
      .cfg_ack    (ocl_cfg_ack),
      .cfg_rdata  (ocl_cfg_rdata)
   );

   // Request path toward the interrupt block
   cfg_stage_pipe #(.WIDTH(REQ_W), .CFG_STAGES(CFG_STAGES)) cfg_req_pipe (
      .clk     (clk_main_a0),
      .rst_n   (ocl_rst_n),
      .in_bus  ({ocl_cfg_wr, ocl_cfg_rd, ocl_cfg_addr, ocl_cfg_wdata}),
      .out_bus ({int_cfg_wr, int_cfg_rd, int_cfg_addr, int_cfg_wdata})
   );

   // Response path back to the slave
   cfg_stage_pipe #(.WIDTH(RSP_W), .CFG_STAGES(CFG_STAGES)) cfg_rsp_pipe (
      .clk     (clk_main_a0),
      .rst_n   (int_rst_n),
      .in_bus  ({int_cfg_ack, int_cfg_rdata}),
      .out_bus ({ocl_cfg_ack, ocl_cfg_rdata})
   );

   int_slv int_tst (
      .clk       (clk_main_a0),
      .rst_n     (int_rst_n),
      .cfg_wr    (int_cfg_wr),
      .cfg_rd    (int_cfg_rd),
      .cfg_addr  (int_cfg_addr),
      .cfg_wdata (int_cfg_wdata),
      .cfg_ack   (int_cfg_ack),
      .cfg_rdata (int_cfg_rdata),
      .irq_req   (irq_req),
      .irq_ack   (irq_ack)
   );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`default_nettype none

/*
 Testbench clock source
*/
module tb_clk_gen #(
   parameter PERIOD = 20
)
(
   output logic clk
);

   // Free running, starts low
   initial
      clk = 1'b0;

   always #(PERIOD/2) clk = ~clk;

endmodule

`default_nettype wire

//--- verification/cl_irq_checker.sv
`default_nettype none

/*
 Protocol checker for the interrupt test top level
 Response hold, interrupt release and FLR done pulse rules
*/
module cl_irq_checker
   import cl_irq_pkg::*;
(
   input wire               clk,
   input wire               pipe_rst_n,
   input wire               b_valid,
   input wire               b_ready,
   input wire               r_valid,
   input wire               r_ready,
   input wire [NUM_IRQ-1:0] irq_req,
   input wire [NUM_IRQ-1:0] irq_ack,
   input wire               flr_assert,
   input wire               flr_done
);

   // Write response held until the host takes it
   b_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      (b_valid && !b_ready) |=> b_valid)
      else $error("b_valid dropped before b_ready");

   // Read response held until the host takes it
   r_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      (r_valid && !r_ready) |=> r_valid)
      else $error("r_valid dropped before r_ready");

   // A request bit only falls after its own ack
   irq_release: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      (($past(irq_req) & ~irq_req & ~$past(irq_ack)) == '0))
      else $error("irq_req bit fell without an ack");

   // One FLR pulse gives one done pulse, two edges after it is seen
   flr_single: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      ($rose(flr_assert) ##1 !flr_assert) |=> (flr_done ##1 !flr_done))
      else $error("flr_done missing or high two cycles in a row after an FLR pulse");

endmodule

bind cl_irq_top cl_irq_checker chk (
   .clk        (clk_main_a0),
   .pipe_rst_n (pipe_rst_n),
   .b_valid    (b_valid),
   .b_ready    (b_ready),
   .r_valid    (r_valid),
   .r_ready    (r_ready),
   .irq_req    (irq_req),
   .irq_ack    (irq_ack),
   .flr_assert (flr_assert),
   .flr_done   (flr_done)
);

`default_nettype wire

//--- verification/tb_cl_irq.sv
`default_nettype none

/*
 Testbench for the interrupt test top level
 Replays the golden file on the host port, models the interrupt host
 and checks every response against the expected values
*/
module tb_cl_irq
   import cl_irq_pkg::*;
();

   localparam DRIVE_DLY  = 2;
   localparam TIMEOUT    = 200;
   localparam RST_CYCLES = 10;

   logic                clk;
   logic                pipe_rst_n;
   logic                flr_assert;
   logic                flr_done;
   logic                aw_valid;
   logic [ADDR_W-1:0]   aw_addr;
   logic                aw_ready;
   logic                w_valid;
   logic [DATA_W-1:0]   w_data;
   logic [DATA_W/8-1:0] w_strb;
   logic                w_ready;
   logic                b_valid;
   logic [1:0]          b_resp;
   logic                b_ready;
   logic                ar_valid;
   logic [ADDR_W-1:0]   ar_addr;
   logic                ar_ready;
   logic                r_valid;
   logic [DATA_W-1:0]   r_data;
   logic [1:0]          r_resp;
   logic                r_ready;
   logic [NUM_IRQ-1:0]  irq_req;
   logic [NUM_IRQ-1:0]  irq_ack;
   int                  fd;
   int                  ops_done;

   tb_clk_gen #(.PERIOD(20)) clk_gen (.clk(clk));

   cl_irq_top i_cl_irq_top (
      .clk_main_a0 (clk),
      .pipe_rst_n  (pipe_rst_n),
      .flr_assert  (flr_assert),
      .flr_done    (flr_done),
      .aw_valid    (aw_valid),
      .aw_addr     (aw_addr),
      .aw_ready    (aw_ready),
      .w_valid     (w_valid),
      .w_data      (w_data),
      .w_strb      (w_strb),
      .w_ready     (w_ready),
      .b_valid     (b_valid),
      .b_resp      (b_resp),
      .b_ready     (b_ready),
      .ar_valid    (ar_valid),
      .ar_addr     (ar_addr),
      .ar_ready    (ar_ready),
      .r_valid     (r_valid),
      .r_data      (r_data),
      .r_resp      (r_resp),
      .r_ready     (r_ready),
      .irq_req     (irq_req),
      .irq_ack     (irq_ack)
   );

   // Next drive point, just after a rising edge
   task automatic step_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                  input logic [DATA_W-1:0] exp);
      $display("test failed");
      $display("FAILED time %0t: %s is %h, expected %h", $time, name, got, exp);
      $fatal(1);
   endtask

   task automatic abort_run(input string what);
      $display("test failed");
      $display("Error at time %0t: %s", $time, what);
      $fatal(1);
   endtask

   // ------------------------------
   // Host port accesses
   // ------------------------------
   task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb, input logic [1:0] exp_resp);
      int          n;
      int unsigned hold;
      logic [1:0]  resp;
      aw_valid = 1'b1;
      aw_addr  = addr;
      w_valid  = 1'b1;
      w_data   = data;
      w_strb   = strb;
      n = 0;
      while (!(aw_ready && w_ready))
      begin
         step_cycle();
         n++;
         if (n > TIMEOUT)
            abort_run("write address and data were never accepted");
      end
      // Transfer on this edge
      step_cycle();
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      n = 0;
      while (!b_valid)
      begin
         step_cycle();
         n++;
         if (n > TIMEOUT)
            abort_run("no write response arrived");
      end
      // Stall the response for a while
      hold = $urandom % 6;
      repeat (hold) step_cycle();
      resp    = b_resp;
      b_ready = 1'b1;
      step_cycle();
      b_ready = 1'b0;
      assert (resp == exp_resp)
         else report_mismatch("b_resp", DATA_W'(resp), DATA_W'(exp_resp));
   endtask

   task automatic host_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data,
                            input logic [1:0] exp_resp);
      int                n;
      int unsigned       hold;
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      ar_valid = 1'b1;
      ar_addr  = addr;
      n = 0;
      while (!ar_ready)
      begin
         step_cycle();
         n++;
         if (n > TIMEOUT)
            abort_run("read address was never accepted");
      end
      step_cycle();
      ar_valid = 1'b0;
      n = 0;
      while (!r_valid)
      begin
         step_cycle();
         n++;
         if (n > TIMEOUT)
            abort_run("no read data arrived");
      end
      hold = $urandom % 6;
      repeat (hold) step_cycle();
      data    = r_data;
      resp    = r_resp;
      r_ready = 1'b1;
      step_cycle();
      r_ready = 1'b0;
      assert (data == exp_data)
         else report_mismatch("r_data", data, exp_data);
      assert (resp == exp_resp)
         else report_mismatch("r_resp", DATA_W'(resp), DATA_W'(exp_resp));
   endtask

   // ------------------------------
   // Interrupt host and FLR
   // ------------------------------
   task automatic serve_irqs(input logic [NUM_IRQ-1:0] mask);
      int                 n;
      int                 cyc;
      int                 delay [NUM_IRQ];
      logic [NUM_IRQ-1:0] left;
      logic [NUM_IRQ-1:0] acks;
      n = 0;
      while ((irq_req & mask) != mask)
      begin
         step_cycle();
         n++;
         if (n > TIMEOUT)
            abort_run("interrupt requests never rose");
      end
      assert (irq_req == mask)
         else report_mismatch("irq_req", DATA_W'(irq_req), DATA_W'(mask));
      // Each line gets its own ack delay
      for (int i = 0; i < NUM_IRQ; i++)
         delay[i] = $urandom % 8;
      left = mask;
      cyc  = 0;
      while (left != '0)
      begin
         acks = '0;
         for (int i = 0; i < NUM_IRQ; i++)
         begin
            if (left[i] && (delay[i] == cyc))
               acks[i] = 1'b1;
         end
         irq_ack = acks;
         left    = left & ~acks;
         step_cycle();
         irq_ack = '0;
         // Acked bits gone, the rest still waiting
         assert (irq_req == left)
            else report_mismatch("irq_req", DATA_W'(irq_req), DATA_W'(left));
         cyc++;
         if (cyc > TIMEOUT)
            abort_run("interrupt acknowledge loop did not finish");
      end
   endtask

   task automatic pulse_flr();
      int n;
      flr_assert = 1'b1;
      step_cycle();
      flr_assert = 1'b0;
      n = 0;
      while (!flr_done)
      begin
         step_cycle();
         n++;
         if (n > TIMEOUT)
            abort_run("flr_done never pulsed");
      end
      // Only one done pulse per request
      for (int k = 0; k < 4; k++)
      begin
         step_cycle();
         assert (!flr_done)
            else report_mismatch("flr_done", DATA_W'(flr_done), '0);
      end
   endtask

   initial
   begin
      string               line;
      string               op;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
      logic [DATA_W/8-1:0] strb;
      logic [DATA_W-1:0]   exp_data;
      logic [1:0]          exp_resp;
      int                  fields;
      void'($urandom(32'h7cdabfbc));
      pipe_rst_n = 1'b0;
      flr_assert = 1'b0;
      aw_valid   = 1'b0;
      aw_addr    = '0;
      w_valid    = 1'b0;
      w_data     = '0;
      w_strb     = '0;
      b_ready    = 1'b0;
      ar_valid   = 1'b0;
      ar_addr    = '0;
      r_ready    = 1'b0;
      irq_ack    = '0;
      ops_done   = 0;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      pipe_rst_n = 1'b1;
      // Everything quiet out of reset
      assert ({aw_ready, w_ready, ar_ready, b_valid, r_valid, flr_done, irq_req} == '0)
         else report_mismatch("reset outputs",
                              DATA_W'({aw_ready, w_ready, ar_ready, b_valid, r_valid,
                                       flr_done, irq_req}), '0);

      fd = $fopen("verification/cl_irq_golden.txt", "r");
      if (fd == 0)
         abort_run("cannot open verification/cl_irq_golden.txt");
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         // Comment and blank lines skipped
         if ((line.len() > 1) && (line.getc(0) != "#"))
         begin
            fields = $sscanf(line, "%s %h %h %h %h %h", op, addr, data, strb,
                             exp_data, exp_resp);
            if (fields != 6)
               abort_run("malformed line in the golden file");
            if (op == "write")
               host_write(addr, data, strb, exp_resp);
            else if (op == "read")
               host_read(addr, exp_data, exp_resp);
            else if (op == "irq_ack")
               serve_irqs(data[NUM_IRQ-1:0]);
            else if (op == "flr")
               pulse_flr();
            else
               abort_run({"unknown operation in the golden file: ", op});
            ops_done++;
         end
      end
      $fclose(fd);
      repeat (4) step_cycle();

      if (ops_done > 0)
      begin
         $display("test passed");
         $finish;
      end
      else
      begin
         $display("test failed");
         $display("No stimulus lines were found in the golden file");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

//--- verification/cl_irq_golden.txt
# op addr data strb exp_data exp_resp, all fields hex
# ops: write, read, irq_ack (data is the pending mask to acknowledge), flr
read    00000000 00000000 0 f0001d0f 0
read    00000100 00000000 0 deaddead 2
write   00000100 12345678 f 00000000 2
write   00000000 ffffffff f 00000000 0
read    00000000 00000000 0 f0001d0f 0
write   00000008 a5a5a5a5 f 00000000 0
read    00000008 00000000 0 a5a5a5a5 0
write   00000008 11223344 5 00000000 0
read    00000008 00000000 0 a522a544 0
write   00000008 ffee0000 c 00000000 0
read    00000008 00000000 0 ffeea544 0
write   00001008 00000000 f 00000000 0
write   00001000 0000a503 f 00000000 0
read    00001004 00000000 0 0000a503 0
irq_ack 00000000 0000a503 0 00000000 0
read    00001004 00000000 0 00000000 0
read    00001008 00000000 0 00000006 0
write   00001000 00000f00 f 00000000 0
read    00001004 00000000 0 00000f00 0
irq_ack 00000000 00000f00 0 00000000 0
read    00001008 00000000 0 0000000a 0
write   00001008 00000000 f 00000000 0
read    00001008 00000000 0 00000000 0
read    0000100c 00000000 0 00000000 0
flr     00000000 00000000 0 00000000 0
read    00000008 00000000 0 00000000 0

//--- verilog.f
rtl/cl_irq_pkg.sv
rtl/rst_slc_pipe.sv
rtl/cfg_stage_pipe.sv
rtl/ocl_slv.sv
rtl/int_slv.sv
rtl/cl_irq_top.sv
verification/tb_clk_gen.sv
verification/cl_irq_checker.sv
verification/tb_cl_irq.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the interrupt test with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cl_irq \
   -f verilog.f -o sim_cl_irq || { echo "Verilator build error"; exit 1; }
./obj_dir/sim_cl_irq > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
